// ==== hdl/i2c_bus_pkg.sv ====
package i2c_bus_pkg;

	// ----------------------------------------
	// bus level widths
	// ----------------------------------------

	typedef logic [7:0] byte_t;     // one byte on the wire
	typedef logic [6:0] addr_t;     // 7-bit slave address
	typedef logic [3:0] bit_cnt_t;  // bit index inside a byte

	// ----------------------------------------
	// protocol constants
	// ----------------------------------------

	// our own address on the bus
	localparam addr_t SLAVE_ADDR = 7'h50;

	// flops before the history flop on scl and sda
	localparam int SYNC_STAGES = 2;

endpackage

// ==== hdl/slave_state_pkg.sv ====
package slave_state_pkg;

	// ----------------------------------------
	// transaction control
	// ----------------------------------------

	typedef enum logic [2:0]
	{
		IDLE,       // waiting for start
		ADDR,       // shifting in address and r/w
		ADDR_ACK,   // address ack, plus first byte on reads
		WRITE,      // receiving a data byte
		WRITE_ACK,  // acking a received byte
		READ,       // sending a data byte
		READ_ACK,   // master ack or nack
		WAIT_STOP   // nacked, bus ignored until stop
	} slave_state_t;

	// running sequence values and the match count
	typedef logic [7:0] seq_t;

	localparam seq_t SEQ_FIRST = 8'd1;

endpackage

// ==== hdl/bus_event_if.sv ====
`timescale 1ns/1ps

// synchronized bus events, single cycle pulses plus the sda level
interface bus_event_if;

	logic scl_rise;
	logic scl_fall;
	logic start;
	logic stop;
	logic sda;

	modport src (output scl_rise, output scl_fall, output start, output stop, output sda);

	modport sink (input scl_rise, input scl_fall, input start, input stop, input sda);

endinterface

// requests from the fsm to the sda driver
interface sda_drive_if import i2c_bus_pkg::*; ();

	logic  ack_req;    // one cycle pulse
	logic  tx_req;     // one cycle pulse
	byte_t tx_byte;    // sampled with tx_req
	logic  cancel;     // drop everything now
	logic  slot_done;  // end of a drive phase

	modport ctrl (output ack_req, output tx_req, output tx_byte, output cancel,
		input slot_done);

	modport driver (input ack_req, input tx_req, input tx_byte, input cancel,
		output slot_done);

endinterface

// ==== hdl/scl_sda_sync.sv ====
`timescale 1ns/1ps

module scl_sda_sync import i2c_bus_pkg::*;
(
	input  logic       clock,
	input  logic       reset_n2,
	input  logic       scl,
	input  logic       sda_in,
	bus_event_if.src   ev
);

	logic [SYNC_STAGES-1:0] scl_sync;
	logic [SYNC_STAGES-1:0] sda_sync;
	logic                   scl_hist;
	logic                   sda_hist;
	logic                   scl_now;
	logic                   sda_now;

	assign scl_now = scl_sync[SYNC_STAGES-1];
	assign sda_now = sda_sync[SYNC_STAGES-1];

	// ----------------------------------------
	// synchronizer and history
	// ----------------------------------------
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			scl_sync <= '1;  // idle bus is high
			sda_sync <= '1;
			scl_hist <= 1'b1;
			sda_hist <= 1'b1;
		end
		else
		begin
			scl_sync <= {scl_sync[SYNC_STAGES-2:0], scl};
			sda_sync <= {sda_sync[SYNC_STAGES-2:0], sda_in};
			scl_hist <= scl_now;
			sda_hist <= sda_now;
		end
	end

	// ----------------------------------------
	// registered event pulses
	// ----------------------------------------
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			ev.scl_rise <= 1'b0;
			ev.scl_fall <= 1'b0;
			ev.start    <= 1'b0;
			ev.stop     <= 1'b0;
			ev.sda      <= 1'b1;
		end
		else
		begin
			ev.scl_rise <= scl_now & ~scl_hist;
			ev.scl_fall <= ~scl_now & scl_hist;
			ev.start    <= scl_now & scl_hist & sda_hist & ~sda_now;  // sda falls, scl high
			ev.stop     <= scl_now & scl_hist & ~sda_hist & sda_now;  // sda rises, scl high
			ev.sda      <= sda_hist;
		end
	end

endmodule

// ==== hdl/rx_shifter.sv ====
`timescale 1ns/1ps

module rx_shifter import i2c_bus_pkg::*;
(
	input  logic       clock,
	input  logic       reset_n2,
	bus_event_if.sink  ev,
	input  logic       rx_enable,
	output byte_t      rx_byte,
	output logic       byte_done
);

	bit_cnt_t bit_cnt;

	// msb first, one bit per scl rise
	always_ff @(posedge clock)
	begin
		if (rx_enable && ev.scl_rise)
			rx_byte <= {rx_byte[6:0], ev.sda};
	end

	// bit count and end of byte
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			bit_cnt   <= '0;
			byte_done <= 1'b0;
		end
		else
		begin
			byte_done <= 1'b0;
			if (!rx_enable || ev.start || ev.stop)  // restart at every new phase
				bit_cnt <= '0;
			else if (ev.scl_rise)
			begin
				byte_done <= (bit_cnt == 4'd7);
				bit_cnt   <= (bit_cnt == 4'd7) ? 4'd0 : bit_cnt + 4'd1;
			end
		end
	end

endmodule

// ==== hdl/sda_driver.sv ====
`timescale 1ns/1ps

module sda_driver import i2c_bus_pkg::*;
(
	input  logic        clock,
	input  logic        reset_n2,
	bus_event_if.sink   ev,
	sda_drive_if.driver drv,
	output logic        sda_out,
	output logic        sda_en
);

	logic     ack_pend;
	logic     tx_pend;
	logic     ack_act;
	logic     tx_act;
	bit_cnt_t bit_cnt;
	byte_t    tx_hold;   // byte waiting for its slot
	byte_t    shreg;
	logic     load_byte;

	// byte starts right after an ack, or on its own when nothing else waits
	assign load_byte = tx_pend & ~tx_act & (ack_act | ~ack_pend);

	always_ff @(posedge clock)
	begin
		if (drv.tx_req)
			tx_hold <= drv.tx_byte;
		if (ev.scl_fall && load_byte)
			shreg <= tx_hold;
		else if (ev.scl_fall && tx_act)
			shreg <= {shreg[6:0], 1'b0};
	end

	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			{ack_pend, tx_pend, ack_act, tx_act} <= 4'b0000;
			bit_cnt       <= '0;
			sda_out       <= 1'b0;
			sda_en        <= 1'b0;
			drv.slot_done <= 1'b0;
		end
		else if (drv.cancel)  // start or stop seen
		begin
			{ack_pend, tx_pend, ack_act, tx_act} <= 4'b0000;
			sda_out       <= 1'b0;
			sda_en        <= 1'b0;
			drv.slot_done <= 1'b0;
		end
		else
		begin
			drv.slot_done <= 1'b0;
			if (ev.scl_fall)
			begin
				if (load_byte)
				begin
					{ack_act, tx_act, tx_pend} <= 3'b010;
					bit_cnt <= 4'd7;
					sda_out <= tx_hold[7];
					sda_en  <= 1'b1;
				end
				else if (ack_act || (tx_act && bit_cnt == 4'd0))
				begin
					{ack_act, tx_act} <= 2'b00;  // phase over, release
					sda_out       <= 1'b0;
					sda_en        <= 1'b0;
					drv.slot_done <= 1'b1;
				end
				else if (tx_act)
				begin
					bit_cnt <= bit_cnt - 4'd1;
					sda_out <= shreg[6];
				end
				else if (ack_pend)
				begin
					{ack_act, ack_pend} <= 2'b10;
					sda_out <= 1'b0;  // ack is a driven low
					sda_en  <= 1'b1;
				end
			end
			if (drv.ack_req)
				ack_pend <= 1'b1;
			if (drv.tx_req)
				tx_pend <= 1'b1;
		end
	end

endmodule

// ==== hdl/seq_tracker.sv ====
`timescale 1ns/1ps

module seq_tracker import i2c_bus_pkg::*, slave_state_pkg::*;
(
	input  logic clock,
	input  logic reset_n2,
	input  logic check,
	input  byte_t rx_byte,
	input  logic next_read,
	output seq_t read_byte,
	output seq_t match_count
);

	seq_t wr_expect;  // next value the master should write

	// ----------------------------------------
	// write side
	// ----------------------------------------
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			wr_expect   <= SEQ_FIRST;
			match_count <= '0;
		end
		else if (check)
		begin
			wr_expect <= wr_expect + 8'd1;  // advances on every byte, good or bad
			if (rx_byte == wr_expect)
				match_count <= match_count + 8'd1;
		end
	end

	// ----------------------------------------
	// read side
	// ----------------------------------------
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
			read_byte <= SEQ_FIRST;
		else if (next_read)
			read_byte <= read_byte + 8'd1;  // wraps
	end

endmodule

// ==== hdl/i2c_slave_ctrl.sv ====
`timescale 1ns/1ps

module i2c_slave_ctrl import i2c_bus_pkg::*, slave_state_pkg::*;
(
	input  logic      clock,
	input  logic      reset_n2,
	bus_event_if.sink ev,
	sda_drive_if.ctrl drv,
	output logic      rx_enable,
	input  byte_t     rx_byte,
	input  logic      byte_done,
	output logic      check,
	output logic      next_read,
	input  seq_t      read_byte
);

	slave_state_t state;
	logic         rw;       // 1 for a read transfer
	addr_t        rx_addr;

	assign rx_addr   = rx_byte[7:1];
	assign rx_enable = (state == ADDR) || (state == WRITE);

	// byte is sampled by the driver together with tx_req
	assign drv.tx_byte = read_byte;

	// ----------------------------------------
	// transaction fsm
	// ----------------------------------------
	always_ff @(posedge clock or negedge reset_n2)
	begin
		if (!reset_n2)
		begin
			state       <= IDLE;
			rw          <= 1'b0;
			drv.ack_req <= 1'b0;
			drv.tx_req  <= 1'b0;
			drv.cancel  <= 1'b0;
			check       <= 1'b0;
			next_read   <= 1'b0;
		end
		else
		begin
			// pulses by default low
			drv.ack_req <= 1'b0;
			drv.tx_req  <= 1'b0;
			drv.cancel  <= 1'b0;
			check       <= 1'b0;
			next_read   <= 1'b0;

			if (ev.start)  // also covers repeated start
			begin
				state      <= ADDR;
				drv.cancel <= 1'b1;
			end
			else if (ev.stop)
			begin
				state      <= IDLE;
				drv.cancel <= 1'b1;
			end
			else
			begin
				case (state)
				ADDR:
				begin
					if (byte_done)
					begin
						if (rx_addr == SLAVE_ADDR)
						begin
							rw          <= rx_byte[0];
							drv.ack_req <= 1'b1;
							drv.tx_req  <= rx_byte[0];  // first read byte follows the ack
							next_read   <= rx_byte[0];
							state       <= ADDR_ACK;
						end
						else
							state <= IDLE;  // not ours, stay off the bus
					end
				end
				ADDR_ACK:
				begin
					if (drv.slot_done)
						state <= rw ? READ_ACK : WRITE;
				end
				WRITE:
				begin
					if (byte_done)
					begin
						check       <= 1'b1;
						drv.ack_req <= 1'b1;
						state       <= WRITE_ACK;
					end
				end
				WRITE_ACK:
				begin
					if (drv.slot_done)
						state <= WRITE;
				end
				READ:
				begin
					if (drv.slot_done)
						state <= READ_ACK;
				end
				READ_ACK:
				begin
					// master ack low means another byte
					if (ev.scl_rise)
					begin
						if (!ev.sda)
						begin
							drv.tx_req <= 1'b1;
							next_read  <= 1'b1;
							state      <= READ;
						end
						else
							state <= WAIT_STOP;
					end
				end
				IDLE, WAIT_STOP:
					state <= state;  // only start or stop moves on
				default:
					state <= IDLE;
				endcase
			end
		end
	end

endmodule

// ==== hdl/i2c_slave_top.sv ====
`timescale 1ns/1ps

module i2c_slave_top import i2c_bus_pkg::*, slave_state_pkg::*;
(
	input  logic clock,
	input  logic reset_n2,
	input  logic scl,
	input  logic sda_in,
	output logic sda_out,
	output logic sda_en,
	output seq_t match_count
);

	logic  rx_enable;
	byte_t rx_byte;
	logic  byte_done;
	logic  check;
	logic  next_read;
	seq_t  read_byte;

	bus_event_if ev ();
	sda_drive_if drv ();

	// ----------------------------------------
	// datapath around the fsm
	// ----------------------------------------
	scl_sda_sync u_sync (.clock(clock), .reset_n2(reset_n2), .scl(scl), .sda_in(sda_in),
		.ev(ev.src));

	rx_shifter u_rx (.clock(clock), .reset_n2(reset_n2), .ev(ev.sink), .rx_enable(rx_enable),
		.rx_byte(rx_byte), .byte_done(byte_done));

	sda_driver u_drv (.clock(clock), .reset_n2(reset_n2), .ev(ev.sink), .drv(drv.driver),
		.sda_out(sda_out), .sda_en(sda_en));

	seq_tracker u_seq (.clock(clock), .reset_n2(reset_n2), .check(check), .rx_byte(rx_byte),
		.next_read(next_read), .read_byte(read_byte), .match_count(match_count));

	// control
	i2c_slave_ctrl u_ctrl (
		.clock     (clock),
		.reset_n2  (reset_n2),
		.ev        (ev.sink),
		.drv       (drv.ctrl),
		.rx_enable (rx_enable),
		.rx_byte   (rx_byte),
		.byte_done (byte_done),
		.check     (check),
		.next_read (next_read),
		.read_byte (read_byte)
	);

endmodule

// ==== tests/i2c_slave_chk.sv ====
`timescale 1ns/1ps

module i2c_slave_chk import slave_state_pkg::*;
(
	input logic clock,
	input logic reset_n2,
	input logic scl,
	input logic sda_out,
	input logic sda_en,
	input seq_t match_count
);

	int assert_fails = 0;

	// ----------------------------------------
	// sda drive timing
	// ----------------------------------------

	// drive changes land 4 cycles after the scl fall at the pin
	sda_en_after_fall: assert property (@(posedge clock) disable iff (!reset_n2)
		$changed(sda_en) |-> !scl && ($past(scl, 5) || $past(scl, 4) || $past(scl, 3)
			|| $past(scl, 2)))
	else
	begin
		assert_fails++;
		$error("sda_en changed away from an scl falling edge");
	end

	sda_out_held: assert property (@(posedge clock) disable iff (!reset_n2)
		scl && sda_en && $past(scl) && $past(sda_en) |-> $stable(sda_out))
	else
	begin
		assert_fails++;
		$error("sda_out moved while scl was high and the slave was driving");
	end

	// good bytes only ever add one
	match_count_step: assert property (@(posedge clock) disable iff (!reset_n2)
		$changed(match_count) |-> match_count == $past(match_count) + 8'd1)
	else
	begin
		assert_fails++;
		$error("match_count jumped by more than one");
	end

endmodule

bind i2c_slave_top i2c_slave_chk chk0 (.clock(clock), .reset_n2(reset_n2), .scl(scl),
	.sda_out(sda_out), .sda_en(sda_en), .match_count(match_count));

// ==== tests/tb_i2c_slave.sv ====
`timescale 1ns/1ps

module tb_i2c_slave import i2c_bus_pkg::*, slave_state_pkg::*; ();

	localparam int  NUM_VEC     = 10;
	localparam int  VEC_WORDS   = 9;  // op addr cnt b0..b3 ack mcnt
	localparam time WATCHDOG_NS = NUM_VEC * 10 * 9 * 24 * 20;

	logic  clock;
	logic  reset_n2;
	logic  scl;
	logic  sda_in;
	logic  sda_out;
	logic  sda_en;
	seq_t  match_count;
	byte_t vec_mem [0:NUM_VEC*VEC_WORDS-1];
	logic  drive_seen;  // slave touched sda since last clear

	i2c_slave_top dut0 (.clock(clock), .reset_n2(reset_n2), .scl(scl), .sda_in(sda_in),
		.sda_out(sda_out), .sda_en(sda_en), .match_count(match_count));

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock)
	begin
		if (sda_en)
			drive_seen = 1'b1;
	end

	initial
	begin
		#(WATCHDOG_NS);
		stop_with_failure("Timeout: the I2C transfers did not finish in the expected time");
	end

	// ----------------------------------------
	// reporting and timing helpers
	// ----------------------------------------
	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		stop_with_failure($sformatf("Mismatch at %0t: %s", $time, msg));
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	function automatic int pick_half();
		return 8 + ($urandom % 5);  // scl phase, 8 to 12 cycles
	endfunction

	// ----------------------------------------
	// bit-banged master
	// ----------------------------------------
	task automatic clock_bit(input logic bit_out, output logic bit_seen);
		int half;
		half = pick_half();
		wait_cycles(half / 2);
		sda_in = bit_out;
		wait_cycles(half - half / 2);
		scl = 1'b1;
		wait_cycles(half / 2);
		bit_seen = sda_en ? sda_out : sda_in;  // resolved bus
		wait_cycles(half - half / 2);
		scl = 1'b0;
	endtask

	task automatic send_start();
		int half;
		half = pick_half();
		if (!scl)
		begin
			// repeated start, lift sda then scl
			wait_cycles(half / 2);
			sda_in = 1'b1;
			wait_cycles(half - half / 2);
			scl = 1'b1;
		end
		wait_cycles(half);
		sda_in = 1'b0;
		wait_cycles(half);
		scl = 1'b0;
	endtask

	task automatic send_stop();
		int half;
		half = pick_half();
		wait_cycles(half / 2);
		sda_in = 1'b0;
		wait_cycles(half - half / 2);
		scl = 1'b1;
		wait_cycles(half);
		sda_in = 1'b1;
		wait_cycles(half);
	endtask

	task automatic write_byte(input byte_t data, output logic ack_bit);
		logic seen;
		for (int i = 7; i >= 0; i--)
			clock_bit(data[i], seen);
		clock_bit(1'b1, ack_bit);  // released for the slave
	endtask

	task automatic read_data(input logic master_ack, output byte_t data);
		logic seen;
		for (int i = 7; i >= 0; i--)
		begin
			clock_bit(1'b1, seen);
			data[i] = seen;
		end
		clock_bit(!master_ack, seen);
	endtask

	// ----------------------------------------
	// one vector line
	// ----------------------------------------
	task automatic run_vector(input int v);
		int    base;
		byte_t op;
		byte_t addr;
		int    cnt;
		logic  exp_ack;
		byte_t exp_count;
		logic  ack_bit;
		byte_t data;
		base      = v * VEC_WORDS;
		op        = vec_mem[base];
		addr      = vec_mem[base+1];
		cnt       = vec_mem[base+2];
		exp_ack   = vec_mem[base+7][0];
		exp_count = vec_mem[base+8];
		send_start();
		drive_seen = 1'b0;
		write_byte({addr[6:0], op == 8'h01}, ack_bit);
		assert (ack_bit == !exp_ack)
		else
			report_mismatch($sformatf("vector %0d address %02h ack bit %0b", v, addr, ack_bit));
		for (int i = 0; i < cnt; i++)
		begin
			if (op == 8'h01)
			begin
				read_data(i < cnt - 1, data);  // nack on the last byte
				assert (data == vec_mem[base+3+i])
				else
					report_mismatch($sformatf("vector %0d read byte %0d got %02h expected %02h",
						v, i, data, vec_mem[base+3+i]));
			end
			else
			begin
				write_byte(vec_mem[base+3+i], ack_bit);
				assert (ack_bit == !exp_ack)
				else
					report_mismatch($sformatf("vector %0d data ack bit %0b", v, ack_bit));
			end
		end
		if (op == 8'h01 && exp_ack)
			drive_seen = 1'b0;  // watch for drive after the master nack
		if (op != 8'h02)
			send_stop();
		assert (!((op == 8'h01 || !exp_ack) && drive_seen))
		else
			report_mismatch($sformatf("vector %0d slave drove sda when it should be off", v));
		assert (match_count == exp_count)
		else
			report_mismatch($sformatf("vector %0d match_count %0d expected %0d", v,
				match_count, exp_count));
	endtask

	initial
	begin
		void'($urandom(32'h1b807767));
		reset_n2   = 1'b0;
		scl        = 1'b1;
		sda_in     = 1'b1;
		drive_seen = 1'b0;
		$readmemh("tests/i2c_vectors.txt", vec_mem);
		assert (vec_mem[0] !== 8'hxx)
		else
			stop_with_failure("Could not read the vector file tests/i2c_vectors.txt");
		wait_cycles(2);
		reset_n2 = 1'b1;
		wait_cycles(4);
		assert (sda_en == 1'b0 && sda_out == 1'b0 && match_count == '0)
		else
			report_mismatch("outputs not cleared after reset");
		for (int v = 0; v < NUM_VEC; v++)
			run_vector(v);
		wait_cycles(10);
		if (dut0.chk0.assert_fails == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
			stop_with_failure("Bound bus assertions failed during the run");
	end

endmodule

// ==== vlog.f ====
hdl/i2c_bus_pkg.sv
hdl/slave_state_pkg.sv
hdl/bus_event_if.sv
hdl/scl_sda_sync.sv
hdl/rx_shifter.sv
hdl/sda_driver.sv
hdl/seq_tracker.sv
hdl/i2c_slave_ctrl.sv
hdl/i2c_slave_top.sv
tests/i2c_slave_chk.sv
tests/tb_i2c_slave.sv

// ==== tests/i2c_vectors.txt ====
// op addr cnt b0 b1 b2 b3 ack mcnt (hex)
// op 00 write then stop, 01 read then stop, 02 write then repeated start
// b0..b3 are bytes to write or bytes expected back, unused ones are 00
// ack 01 means the address is acked, mcnt is match_count at the end
00 50 03 01 02 03 00 01 03
01 50 03 01 02 03 00 01 03
00 51 02 04 05 00 00 00 03
00 50 04 04 aa 06 07 01 06
01 50 02 04 05 00 00 01 06
02 50 02 08 09 00 00 01 08
01 50 03 06 07 08 00 01 08
01 48 01 ff 00 00 00 00 08
00 50 01 0a 00 00 00 01 09
01 50 01 09 00 00 00 01 09
